/* common/array_pkg.sv */
/*
 * Shared widths, channel count and types for the array drive subsystem
 * Register map, control flag bits and the version word
 */
`default_nettype none

package array_pkg;

  localparam int N_CH = 8;
  localparam int CH_W = $clog2(N_CH);
  localparam int ADDR_W = 6;
  localparam int RAM_DEPTH = 1 << ADDR_W;

  // Worst case cycles from a CPU write to the matching output
  localparam int LOOP_MAX = 2 * N_CH + 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [15:0] word_t;
  typedef logic [15:0] cycle_t;
  typedef logic [63:0] sync_time_t;

  localparam word_t VERSION_NUM = 16'h00A3;

  // Control flag word
  localparam int FLAG_SYNC_BIT = 0;
  localparam int FLAG_OUT_EN_BIT = 1;
  localparam int FLAG_FORCE_FAN_BIT = 2;

  localparam addr_t ADDR_CTL_FLAG = 6'd0;
  localparam addr_t ADDR_VERSION = 6'd1;
  localparam addr_t ADDR_STATUS = 6'd2;   // Bit 0 holds the thermal flag
  localparam addr_t ADDR_CYCLE = 6'd3;
  localparam addr_t ADDR_SYNC_TIME_0 = 6'd4;  // Lowest word first
  localparam addr_t ADDR_SYNC_TIME_1 = 6'd5;
  localparam addr_t ADDR_SYNC_TIME_2 = 6'd6;
  localparam addr_t ADDR_SYNC_TIME_3 = 6'd7;

  // Per-channel tables, entry i at base plus i
  localparam addr_t ADDR_DELAY_BASE = 6'd16;
  localparam addr_t ADDR_DUTY_BASE = 6'd32;

endpackage

`default_nettype wire

/* design/reg_ram.sv */
/*
 * Register memory shared by the CPU port and the controller
 * Two synchronous ports, controller write wins on a collision
 */
`timescale 1ns/1ps
`default_nettype none

module reg_ram (
  input  logic             CLK,
  input  logic             cpu_en,
  input  logic             cpu_we,
  input  array_pkg::addr_t cpu_addr,
  input  array_pkg::word_t cpu_wdata,
  output array_pkg::word_t cpu_rdata,
  input  logic             ctl_we,
  input  array_pkg::addr_t ctl_addr,
  input  array_pkg::word_t ctl_wdata,
  output array_pkg::word_t ctl_rdata
);
  import array_pkg::*;

  word_t mem [RAM_DEPTH];

  // Writes from both ports
  always_ff @(posedge CLK) begin
    if (cpu_en && cpu_we) begin
      mem[cpu_addr] <= cpu_wdata;
    end
    // Later assignment takes effect, so the controller wins on the same address
    if (ctl_we) begin
      mem[ctl_addr] <= ctl_wdata;
    end
  end

  // CPU read data holds until the next read strobe
  always_ff @(posedge CLK) begin
    if (cpu_en && !cpu_we) begin
      cpu_rdata <= mem[cpu_addr];
    end
  end

  always_ff @(posedge CLK) begin
    ctl_rdata <= mem[ctl_addr];  // Old contents during a write
  end

endmodule

`default_nettype wire

/* controller/controller.sv */
/*
 * Register polling FSM with version write, status write-back,
 * sync time capture, delay and duty table sweep and the time counter
 */
`timescale 1ns/1ps
`default_nettype none

module controller (
  input  logic                  CLK,
  input  logic                  reset,
  input  array_pkg::word_t      ctl_rdata,
  input  logic                  thermo,
  output logic                  ctl_we,
  output array_pkg::addr_t      ctl_addr,
  output array_pkg::word_t      ctl_wdata,
  output array_pkg::cycle_t     cycle,
  output array_pkg::cycle_t     time_cnt,
  output array_pkg::cycle_t     delay [array_pkg::N_CH],
  output array_pkg::cycle_t     duty [array_pkg::N_CH],
  output array_pkg::sync_time_t sync_time,
  output logic                  sync_set,
  output logic                  out_en,
  output logic                  force_fan
);
  import array_pkg::*;

  // Read data arrives two states after the state that sets the address
  typedef enum logic [3:0] {
    INIT_WR_VER,
    REQ_FLAG,
    REQ_CYCLE,
    RD_FLAG_WR_STATUS,
    RD_CYCLE_REQ_DELAY,
    SWEEP_DUTY,
    SWEEP_DELAY,
    RD_LAST_DELAY_REQ_FLAG,
    RD_LAST_DUTY_REQ_CYCLE,
    SYNC_REQ_1,
    SYNC_REQ_2_RD_0,
    SYNC_REQ_3_RD_1,
    SYNC_RD_2_CLR_FLAG,
    SYNC_RD_3_SET
  } ctl_state_t;

  ctl_state_t state;
  word_t flags;
  logic [CH_W-1:0] ch;
  logic [CH_W-1:0] prev_ch;

  assign prev_ch = ch - 1'b1;
  assign out_en = flags[FLAG_OUT_EN_BIT];
  assign force_fan = flags[FLAG_FORCE_FAN_BIT];

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= INIT_WR_VER;
      ctl_we <= 1'b0;
      sync_set <= 1'b0;
      flags <= '0;
      cycle <= '0;
      ch <= '0;
    end else begin
      sync_set <= 1'b0;
      case (state)
        INIT_WR_VER: begin
          ctl_we <= 1'b1;
          ctl_addr <= ADDR_VERSION;
          ctl_wdata <= VERSION_NUM;
          state <= REQ_FLAG;
        end
        REQ_FLAG: begin
          ctl_we <= 1'b0;
          ctl_addr <= ADDR_CTL_FLAG;
          state <= REQ_CYCLE;
        end
        REQ_CYCLE: begin
          ctl_addr <= ADDR_CYCLE;
          state <= RD_FLAG_WR_STATUS;
        end
        RD_FLAG_WR_STATUS: begin
          flags <= ctl_rdata;
          ctl_we <= 1'b1;
          ctl_addr <= ADDR_STATUS;
          ctl_wdata <= {15'd0, thermo};
          ch <= '0;
          state <= RD_CYCLE_REQ_DELAY;
        end
        RD_CYCLE_REQ_DELAY: begin
          cycle <= ctl_rdata;
          ctl_we <= 1'b0;
          if (flags[FLAG_SYNC_BIT]) begin
            ctl_addr <= ADDR_SYNC_TIME_0;
            state <= SYNC_REQ_1;
          end else begin
            ctl_addr <= ADDR_DELAY_BASE;  // Channel 0
            state <= SWEEP_DUTY;
          end
        end
        SWEEP_DUTY: begin
          ctl_addr <= ADDR_DUTY_BASE + addr_t'(ch);
          if (ch != '0) begin
            duty[prev_ch] <= ctl_rdata;
          end
          if (ch == CH_W'(N_CH - 1)) begin
            state <= RD_LAST_DELAY_REQ_FLAG;
          end else begin
            ch <= ch + 1'b1;
            state <= SWEEP_DELAY;
          end
        end
        SWEEP_DELAY: begin
          ctl_addr <= ADDR_DELAY_BASE + addr_t'(ch);
          delay[prev_ch] <= ctl_rdata;
          state <= SWEEP_DUTY;
        end
        // Last channel's reads drain while the next loop starts
        RD_LAST_DELAY_REQ_FLAG: begin
          delay[ch] <= ctl_rdata;
          ctl_addr <= ADDR_CTL_FLAG;
          state <= RD_LAST_DUTY_REQ_CYCLE;
        end
        RD_LAST_DUTY_REQ_CYCLE: begin
          duty[ch] <= ctl_rdata;
          ctl_addr <= ADDR_CYCLE;
          state <= RD_FLAG_WR_STATUS;
        end
        SYNC_REQ_1: begin
          ctl_addr <= ADDR_SYNC_TIME_1;
          state <= SYNC_REQ_2_RD_0;
        end
        SYNC_REQ_2_RD_0: begin
          ctl_addr <= ADDR_SYNC_TIME_2;
          sync_time[15:0] <= ctl_rdata;
          state <= SYNC_REQ_3_RD_1;
        end
        SYNC_REQ_3_RD_1: begin
          ctl_addr <= ADDR_SYNC_TIME_3;
          sync_time[31:16] <= ctl_rdata;
          state <= SYNC_RD_2_CLR_FLAG;
        end
        SYNC_RD_2_CLR_FLAG: begin
          sync_time[47:32] <= ctl_rdata;
          // Flags as read this loop, request bit dropped
          ctl_we <= 1'b1;
          ctl_addr <= ADDR_CTL_FLAG;
          ctl_wdata <= flags & ~(word_t'(1) << FLAG_SYNC_BIT);
          state <= SYNC_RD_3_SET;
        end
        SYNC_RD_3_SET: begin
          sync_time[63:48] <= ctl_rdata;
          ctl_we <= 1'b0;
          sync_set <= 1'b1;
          state <= REQ_FLAG;
        end
        default: begin
          state <= INIT_WR_VER;
        end
      endcase
    end
  end

  // Shared time base, restarted on the sync_set edge
  always_ff @(posedge CLK) begin
    if (reset) begin
      time_cnt <= '0;
    end else if (state == SYNC_RD_3_SET) begin
      time_cnt <= '0;
    end else if (cycle == '0 || time_cnt >= cycle - 1'b1) begin
      time_cnt <= '0;  // A cycle of 0 holds the count
    end else begin
      time_cnt <= time_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/pwm_channel.sv */
/*
 * Delayed pulse generator for one transducer channel
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_channel (
  input  logic              CLK,
  input  logic              reset,
  input  array_pkg::cycle_t time_cnt,
  input  array_pkg::cycle_t cycle,
  input  array_pkg::cycle_t delay,
  input  array_pkg::cycle_t duty,
  output logic              pulse
);
  import array_pkg::*;

  cycle_t phase;
  logic on;

  // Phase within the period counted from the delay, delay taken below cycle
  always_comb begin
    if (time_cnt >= delay) begin
      phase = time_cnt - delay;
    end else begin
      phase = time_cnt + cycle - delay;  // Wrap back into the period
    end
  end

  // Duty 0 is always low, duty of a full period or more always high
  assign on = (duty != '0) && ((duty >= cycle) || (phase < duty));

  always_ff @(posedge CLK) begin
    if (reset) begin
      pulse <= 1'b0;
    end else begin
      pulse <= on;
    end
  end

endmodule

`default_nettype wire

/* design/output_stage.sv */
/*
 * Output register for the drive pulses with output-enable gating
 * and the registered fan request
 */
`timescale 1ns/1ps
`default_nettype none

module output_stage (
  input  logic                       CLK,
  input  logic                       reset,
  input  logic [array_pkg::N_CH-1:0] pulse,
  input  logic                       out_en,
  input  logic                       force_fan,
  input  logic                       thermo,
  output logic [array_pkg::N_CH-1:0] drive,
  output logic                       fan
);
  import array_pkg::*;

  always_ff @(posedge CLK) begin
    if (reset) begin
      drive <= '0;
      fan <= 1'b0;
    end else begin
      drive <= pulse & {N_CH{out_en}};
      fan <= force_fan | thermo;  // Hot array or host request
    end
  end

endmodule

`default_nettype wire

/* design/array_top.sv */
/*
 * Array drive top level
 * Register memory, controller, per-channel pulse generators and output stage
 */
`timescale 1ns/1ps
`default_nettype none

module array_top (
  input  logic                       CLK,
  input  logic                       reset,
  input  logic                       cpu_en,
  input  logic                       cpu_we,
  input  array_pkg::addr_t           cpu_addr,
  input  array_pkg::word_t           cpu_wdata,
  input  logic                       thermo,
  output array_pkg::word_t           cpu_rdata,
  output logic [array_pkg::N_CH-1:0] drive,
  output logic                       fan,
  output array_pkg::sync_time_t      sync_time,
  output logic                       sync_set
);
  import array_pkg::*;

  logic ctl_we;
  addr_t ctl_addr;
  word_t ctl_wdata;
  word_t ctl_rdata;
  cycle_t cycle;
  cycle_t time_cnt;
  cycle_t delay [N_CH];
  cycle_t duty [N_CH];
  logic out_en;
  logic force_fan;
  logic [N_CH-1:0] pulse;

  reg_ram u_ram (
    .CLK       (CLK),
    .cpu_en    (cpu_en),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_rdata (cpu_rdata),
    .ctl_we    (ctl_we),
    .ctl_addr  (ctl_addr),
    .ctl_wdata (ctl_wdata),
    .ctl_rdata (ctl_rdata)
  );

  controller u_ctl (
    .CLK       (CLK),
    .reset     (reset),
    .ctl_rdata (ctl_rdata),
    .thermo    (thermo),
    .ctl_we    (ctl_we),
    .ctl_addr  (ctl_addr),
    .ctl_wdata (ctl_wdata),
    .cycle     (cycle),
    .time_cnt  (time_cnt),
    .delay     (delay),
    .duty      (duty),
    .sync_time (sync_time),
    .sync_set  (sync_set),
    .out_en    (out_en),
    .force_fan (force_fan)
  );

  for (genvar i = 0; i < N_CH; i++) begin : gen_ch
    pwm_channel u_pwm (
      .CLK      (CLK),
      .reset    (reset),
      .time_cnt (time_cnt),
      .cycle    (cycle),
      .delay    (delay[i]),
      .duty     (duty[i]),
      .pulse    (pulse[i])
    );
  end

  output_stage u_out (
    .CLK       (CLK),
    .reset     (reset),
    .pulse     (pulse),
    .out_en    (out_en),
    .force_fan (force_fan),
    .thermo    (thermo),
    .drive     (drive),
    .fan       (fan)
  );

endmodule

`default_nettype wire

/* tests/array_props.sv */
/*
 * Concurrent checks on the array drive top level
 * Reset quiet, sync pulse width, output gating, fan and time counter range
 */
`timescale 1ns/1ps
`default_nettype none

module array_props (
  input logic                       CLK,
  input logic                       reset,
  input logic [array_pkg::N_CH-1:0] drive,
  input logic                       fan,
  input logic                       sync_set,
  input logic                       out_en,
  input logic                       force_fan,
  input logic                       thermo,
  input array_pkg::cycle_t          time_cnt,
  input array_pkg::cycle_t          cycle
);
  import array_pkg::*;

  int fail_cnt = 0;  // Read by the testbench verdict

  a_reset_quiet: assert property (@(posedge CLK)
    reset |=> (drive == '0 && !fan && !sync_set))
  else begin
    $error("drive, fan or sync_set active around reset");
    fail_cnt++;
  end

  a_sync_one_cycle: assert property (@(posedge CLK) disable iff (reset)
    sync_set |=> !sync_set)
  else begin
    $error("sync_set high for more than one cycle");
    fail_cnt++;
  end

  // Drive register follows out_en of the cycle before
  a_drive_gated: assert property (@(posedge CLK) disable iff (reset)
    !$past(out_en) |-> drive == '0)
  else begin
    $error("drive active while output enable is low");
    fail_cnt++;
  end

  // Fan register adds one cycle
  a_fan_on: assert property (@(posedge CLK) disable iff (reset)
    (force_fan || thermo) |=> fan)
  else begin
    $error("fan did not follow a fan request");
    fail_cnt++;
  end

  a_fan_off: assert property (@(posedge CLK) disable iff (reset)
    !(force_fan || thermo) |=> !fan)
  else begin
    $error("fan stayed on without a request");
    fail_cnt++;
  end

  // Count stays inside the period it was stepped with
  a_time_range: assert property (@(posedge CLK) disable iff (reset)
    $past(cycle) != '0 |-> time_cnt < $past(cycle))
  else begin
    $error("time_cnt outside the modulation cycle");
    fail_cnt++;
  end

  a_time_hold: assert property (@(posedge CLK) disable iff (reset)
    $past(cycle) == '0 |-> time_cnt == '0)
  else begin
    $error("time_cnt moved with a cycle of zero");
    fail_cnt++;
  end

endmodule

bind array_top array_props u_props (
  .CLK       (CLK),
  .reset     (reset),
  .drive     (drive),
  .fan       (fan),
  .sync_set  (sync_set),
  .out_en    (out_en),
  .force_fan (force_fan),
  .thermo    (thermo),
  .time_cnt  (time_cnt),
  .cycle     (cycle)
);

`default_nettype wire

/* tests/tb_array.sv */
/*
 * Testbench for array_top with clock, reset and CPU port stimulus
 * Readback and drive pattern checks, progress lines and the verdict
 */
`timescale 1ns/1ps
`default_nettype none

module tb_array;
  import array_pkg::*;

  localparam int TIMEOUT = 6 * 400;
  localparam int PWM_CYCLE = 20;

  logic CLK;
  logic reset;
  logic cpu_en;
  logic cpu_we;
  addr_t cpu_addr;
  word_t cpu_wdata;
  logic thermo;
  word_t cpu_rdata;
  logic [N_CH-1:0] drive;
  logic fan;
  sync_time_t sync_time;
  logic sync_set;

  int errors = 0;
  int cycles = 0;
  int tests_run = 0;
  int test_start = 0;
  cycle_t dly [N_CH];
  cycle_t duty_val [N_CH];

  array_top DUT (
    .CLK       (CLK),
    .reset     (reset),
    .cpu_en    (cpu_en),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .thermo    (thermo),
    .cpu_rdata (cpu_rdata),
    .drive     (drive),
    .fan       (fan),
    .sync_time (sync_time),
    .sync_set  (sync_set)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run went past %0d cycles", TIMEOUT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Inputs change and outputs are sampled 2 ns after the edge
  task automatic step(input int n = 1);
    repeat (n) begin
      @(posedge CLK);
      #2;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic cpu_write(input addr_t addr, input word_t data);
    cpu_en = 1'b1;
    cpu_we = 1'b1;
    cpu_addr = addr;
    cpu_wdata = data;
    step();
    cpu_en = 1'b0;
    cpu_we = 1'b0;
  endtask

  task automatic cpu_read(input addr_t addr, output word_t data);
    cpu_en = 1'b1;
    cpu_we = 1'b0;
    cpu_addr = addr;
    step();
    cpu_en = 1'b0;
    data = cpu_rdata;
  endtask

  function automatic int total_errors();
    return errors + DUT.u_props.fail_cnt;
  endfunction

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name,
             (total_errors() == test_start) ? "ok" : "errors");
    test_start = total_errors();
  endtask

  // High while (t - delay) mod cycle is below duty
  function automatic logic pulse_expected(input cycle_t t, input cycle_t d,
                                          input cycle_t w, input cycle_t c);
    int phase;
    phase = (int'(t) + int'(c) - int'(d)) % int'(c);
    if (w == '0) begin
      pulse_expected = 1'b0;
    end else if (w >= c) begin
      pulse_expected = 1'b1;
    end else begin
      pulse_expected = phase < int'(w);
    end
  endfunction

  initial begin
    int waited;
    logic exp_bit;
    word_t rd;
    word_t flags_exp;
    sync_time_t sync_exp;
    void'($urandom(32'h3707_0cce));
    reset = 1'b1;
    cpu_en = 1'b0;
    cpu_we = 1'b0;
    cpu_addr = '0;
    cpu_wdata = '0;
    thermo = 1'b0;

    repeat (5) begin
      step();
      check_value("drive", 64'(drive), 64'd0);
      check_value("fan", 64'(fan), 64'd0);
      check_value("sync_set", 64'(sync_set), 64'd0);
    end
    reset = 1'b0;
    step();  // First cycle out of reset
    check_value("drive", 64'(drive), 64'd0);
    check_value("fan", 64'(fan), 64'd0);
    check_value("sync_set", 64'(sync_set), 64'd0);
    end_test("reset");

    step(10);
    cpu_read(ADDR_VERSION, rd);
    check_value("version", 64'(rd), 64'(VERSION_NUM));
    end_test("version");

    sync_exp = {$urandom, $urandom};
    for (int i = 0; i < 4; i++) begin
      cpu_write(addr_t'(ADDR_SYNC_TIME_0 + i), sync_exp[16*i +: 16]);
    end
    flags_exp = word_t'((1 << FLAG_SYNC_BIT) | (1 << FLAG_FORCE_FAN_BIT));
    cpu_write(ADDR_CTL_FLAG, flags_exp);
    waited = 0;
    while (sync_set !== 1'b1 && waited < LOOP_MAX + 12) begin
      step();
      waited++;
    end
    if (sync_set !== 1'b1) begin
      $display("sync_set never pulsed after the sync request was written");
      errors++;
    end else begin
      check_value("sync_time", sync_time, sync_exp);
    end
    step(3);
    cpu_read(ADDR_CTL_FLAG, rd);
    check_value("ctl_flag", 64'(rd), 64'(flags_exp & ~word_t'(1 << FLAG_SYNC_BIT)));
    end_test("sync");

    cpu_write(ADDR_CYCLE, word_t'(PWM_CYCLE));
    for (int i = 0; i < N_CH; i++) begin
      dly[i] = cycle_t'($urandom % PWM_CYCLE);
      duty_val[i] = cycle_t'(1 + $urandom % (PWM_CYCLE - 1));
      if (i == 0) begin
        duty_val[i] = '0;
      end else if (i == N_CH - 1) begin
        duty_val[i] = cycle_t'(PWM_CYCLE + 3);  // Clipped to a full period
      end
      cpu_write(addr_t'(ADDR_DELAY_BASE + i), dly[i]);
      cpu_write(addr_t'(ADDR_DUTY_BASE + i), duty_val[i]);
    end
    repeat (3 * LOOP_MAX) begin
      step();
      check_value("drive", 64'(drive), 64'd0);
    end
    end_test("output disable");

    // A sync together with output enable restarts time_cnt at a known edge
    cpu_write(ADDR_CTL_FLAG, word_t'((1 << FLAG_OUT_EN_BIT) | (1 << FLAG_SYNC_BIT)));
    waited = 0;
    while (sync_set !== 1'b1 && waited < LOOP_MAX + 12) begin
      step();
      waited++;
    end
    if (sync_set !== 1'b1) begin
      $display("sync_set never pulsed before the channel pulse check");
      errors++;
    end
    step(2);  // Drive lags the count by two registers
    for (int n = 0; n < 4 * PWM_CYCLE; n++) begin
      for (int i = 0; i < N_CH; i++) begin
        exp_bit = pulse_expected(cycle_t'(n % PWM_CYCLE), dly[i], duty_val[i],
                                 cycle_t'(PWM_CYCLE));
        assert (drive[i] === exp_bit) else begin
          $display("CHECK FAILED at %0t: drive[%0d] is %b, expected %b",
                   $time, i, drive[i], exp_bit);
          errors++;
        end
      end
      step();
    end
    end_test("channel pulses");

    thermo = 1'b1;
    step(LOOP_MAX + 2);
    check_value("fan", 64'(fan), 64'd1);
    cpu_read(ADDR_STATUS, rd);
    check_value("status", 64'(rd), 64'd1);
    thermo = 1'b0;
    step(LOOP_MAX + 2);
    check_value("fan", 64'(fan), 64'd0);
    cpu_read(ADDR_STATUS, rd);
    check_value("status", 64'(rd), 64'd0);
    cpu_write(ADDR_CTL_FLAG, word_t'((1 << FLAG_OUT_EN_BIT) | (1 << FLAG_FORCE_FAN_BIT)));
    step(LOOP_MAX + 2);
    check_value("fan", 64'(fan), 64'd1);
    end_test("fan and status");

    $display("tests run %0d, testbench errors %0d, assertion failures %0d",
             tests_run, errors, DUT.u_props.fail_cnt);
    if (total_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/array_pkg.sv
design/reg_ram.sv
controller/controller.sv
design/pwm_channel.sv
design/output_stage.sv
design/array_top.sv
tests/array_props.sv
tests/tb_array.sv

/* Makefile */
TOP = tb_array
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No verdict found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
